/* hw/cu_params.svh */
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Instruction register and data bus width
`define CU_DATA_W 8

// Condition code register holds N, Z, V and C
`define CU_CCR_W 4

// ALU function select
`define CU_ALU_SEL_W 3

// Width of each of the two bus source selects
`define CU_BUS_SEL_W 2

// Flag positions inside the condition code register
`define CU_FLAG_N 3 // Negative
`define CU_FLAG_Z 2 // Zero
`define CU_FLAG_V 1 // Overflow
`define CU_FLAG_C 0 // Carry

`endif

/* hw/cu_pkg.sv */
`default_nettype none

`include "cu_params.svh"

package cu_pkg;

	typedef enum logic [`CU_DATA_W-1:0] {
		BRA     = 8'h20, // Branch always
		BMI     = 8'h21,
		BPL     = 8'h22,
		BEQ     = 8'h23,
		BNE     = 8'h24,
		BVS     = 8'h25,
		BVC     = 8'h26,
		BCS     = 8'h27,
		BCC     = 8'h28,
		ADD_AB  = 8'h42, // A <= A + B
		SUB_AB  = 8'h43,
		AND_AB  = 8'h44,
		OR_AB   = 8'h45,
		INCA    = 8'h46,
		DECA    = 8'h48,
		XOR_AB  = 8'h4A,
		NOTA    = 8'h4B,
		LDA_IMM = 8'h86, // Operand is the value itself
		LDA_DIR = 8'h87, // Operand is the address of the value
		LDB_IMM = 8'h88,
		LDB_DIR = 8'h89,
		STA_DIR = 8'h96,
		STB_DIR = 8'h97
	} opcode_e;

	typedef enum logic [`CU_ALU_SEL_W-1:0] {
		ALU_ADD = 3'd0,
		ALU_INC = 3'd1,
		ALU_SUB = 3'd2,
		ALU_DEC = 3'd3,
		ALU_AND = 3'd4,
		ALU_OR  = 3'd5,
		ALU_XOR = 3'd6,
		ALU_NOT = 3'd7
	} alu_op_e;

	typedef enum logic [`CU_BUS_SEL_W-1:0] {
		BUS1_PC = 2'd0,
		BUS1_A  = 2'd1,
		BUS1_B  = 2'd2
	} bus1_sel_e;

	// Bus2 feeds MAR, PC, IR, A and B
	typedef enum logic [`CU_BUS_SEL_W-1:0] {
		BUS2_ALU  = 2'd0,
		BUS2_BUS1 = 2'd1,
		BUS2_MEM  = 2'd2
	} bus2_sel_e;

	typedef enum logic [2:0] {
		CLS_LD_IMM,
		CLS_LD_DIR,
		CLS_ST_DIR,
		CLS_ALU,
		CLS_BRANCH,
		CLS_UNDEF
	} instr_class_e;

	typedef enum logic {
		REG_A,
		REG_B
	} reg_sel_e;

	typedef enum logic [3:0] {
		COND_ALWAYS,
		COND_N_SET,
		COND_N_CLR,
		COND_Z_SET,
		COND_Z_CLR,
		COND_V_SET,
		COND_V_CLR,
		COND_C_SET,
		COND_C_CLR
	} branch_cond_e;

	typedef enum logic [3:0] {
		PH_FETCH_MAR,
		PH_FETCH_INC,
		PH_FETCH_IR,
		PH_DECODE,
		PH_OPR_MAR,  // Operand address from PC
		PH_OPR_INC,
		PH_ADDR_MAR, // Operand byte becomes the address
		PH_MEM_WAIT,
		PH_REG_LOAD,
		PH_STORE,
		PH_ALU_EXEC,
		PH_PC_LOAD,
		PH_SKIP_INC  // Step over the unused branch target
	} phase_e;

	typedef struct packed {
		instr_class_e cls;
		reg_sel_e     reg_sel;
		alu_op_e      alu_op;
		branch_cond_e cond;
	} decoded_instr_t;

	typedef struct packed {
		logic      ir_load;
		logic      mar_load;
		logic      pc_load;
		logic      pc_inc;
		logic      a_load;
		logic      b_load;
		logic      ccr_load;
		alu_op_e   alu_sel;
		bus1_sel_e bus1_sel;
		bus2_sel_e bus2_sel;
		logic      write;
	} ctrl_word_t;

endpackage

`default_nettype wire

/* hw/opcode_decoder.sv */
`default_nettype none

`include "cu_params.svh"

module opcode_decoder
(
	input  logic [`CU_DATA_W-1:0]  ir,
	output cu_pkg::decoded_instr_t dec
);

	import cu_pkg::*;

	always_comb
	begin
		case (ir)
			LDA_IMM, LDB_IMM: dec.cls = CLS_LD_IMM;
			LDA_DIR, LDB_DIR: dec.cls = CLS_LD_DIR;
			STA_DIR, STB_DIR: dec.cls = CLS_ST_DIR;
			ADD_AB, SUB_AB, AND_AB, OR_AB,
			INCA, DECA, XOR_AB, NOTA: dec.cls = CLS_ALU;
			BRA, BMI, BPL, BEQ, BNE,
			BVS, BVC, BCS, BCC: dec.cls = CLS_BRANCH;
			default: dec.cls = CLS_UNDEF; // INCB, NOTB and friends land here too
		endcase

		case (ir)
			LDB_IMM, LDB_DIR, STB_DIR: dec.reg_sel = REG_B;
			default: dec.reg_sel = REG_A;
		endcase

		// Only A-target operations exist
		case (ir)
			SUB_AB: dec.alu_op = ALU_SUB;
			AND_AB: dec.alu_op = ALU_AND;
			OR_AB: dec.alu_op = ALU_OR;
			INCA: dec.alu_op = ALU_INC;
			DECA: dec.alu_op = ALU_DEC;
			XOR_AB: dec.alu_op = ALU_XOR;
			NOTA: dec.alu_op = ALU_NOT;
			default: dec.alu_op = ALU_ADD;
		endcase

		case (ir)
			BMI: dec.cond = COND_N_SET;
			BPL: dec.cond = COND_N_CLR;
			BEQ: dec.cond = COND_Z_SET;
			BNE: dec.cond = COND_Z_CLR;
			BVS: dec.cond = COND_V_SET;
			BVC: dec.cond = COND_V_CLR;
			BCS: dec.cond = COND_C_SET;
			BCC: dec.cond = COND_C_CLR;
			default: dec.cond = COND_ALWAYS; // BRA and non-branches
		endcase
	end

endmodule

`default_nettype wire

/* hw/phase_sequencer.sv */
`default_nettype none

`include "cu_params.svh"

module phase_sequencer
(
	input  logic                   Clk,
	input  logic                   Reset,
	input  cu_pkg::decoded_instr_t dec,
	input  logic [`CU_CCR_W-1:0]   ccr,
	output cu_pkg::phase_e         phase
);

	import cu_pkg::*;

	phase_e next_phase;

	function automatic logic cond_met(input branch_cond_e cond, input logic [`CU_CCR_W-1:0] flags);
		case (cond)
			COND_ALWAYS: return 1'b1;
			COND_N_SET: return flags[`CU_FLAG_N];
			COND_N_CLR: return !flags[`CU_FLAG_N];
			COND_Z_SET: return flags[`CU_FLAG_Z];
			COND_Z_CLR: return !flags[`CU_FLAG_Z];
			COND_V_SET: return flags[`CU_FLAG_V];
			COND_V_CLR: return !flags[`CU_FLAG_V];
			COND_C_SET: return flags[`CU_FLAG_C];
			COND_C_CLR: return !flags[`CU_FLAG_C];
			default: return 1'b0;
		endcase
	endfunction

	always_ff @(posedge Clk or negedge Reset)
	begin
		if (!Reset)
			phase <= PH_FETCH_MAR;
		else
			phase <= next_phase;
	end

	// IR is stable from PH_DECODE onward, so dec steers every execute phase
	always_comb
	begin
		next_phase = PH_FETCH_MAR;
		case (phase)
			PH_FETCH_MAR: next_phase = PH_FETCH_INC;
			PH_FETCH_INC: next_phase = PH_FETCH_IR;
			PH_FETCH_IR: next_phase = PH_DECODE;
			PH_DECODE:
			begin
				case (dec.cls)
					CLS_LD_IMM, CLS_LD_DIR, CLS_ST_DIR: next_phase = PH_OPR_MAR;
					CLS_ALU: next_phase = PH_ALU_EXEC;
					CLS_BRANCH: next_phase = cond_met(dec.cond, ccr) ? PH_OPR_MAR : PH_SKIP_INC;
					default: next_phase = PH_FETCH_MAR; // Undefined opcode is a 4-cycle no-op
				endcase
			end
			PH_OPR_MAR: next_phase = (dec.cls == CLS_BRANCH) ? PH_MEM_WAIT : PH_OPR_INC;
			PH_OPR_INC: next_phase = (dec.cls == CLS_LD_IMM) ? PH_REG_LOAD : PH_ADDR_MAR;
			PH_ADDR_MAR: next_phase = (dec.cls == CLS_ST_DIR) ? PH_STORE : PH_MEM_WAIT;
			PH_MEM_WAIT: next_phase = (dec.cls == CLS_BRANCH) ? PH_PC_LOAD : PH_REG_LOAD;
			default: next_phase = PH_FETCH_MAR; // Final phase of every class
		endcase
	end

endmodule

`default_nettype wire

/* hw/control_word_gen.sv */
`default_nettype none

module control_word_gen
(
	input  cu_pkg::phase_e         phase,
	input  cu_pkg::decoded_instr_t dec,
	output cu_pkg::ctrl_word_t     ctrl
);

	import cu_pkg::*;

	always_comb
	begin
		ctrl = '0; // No strobes, ALU add, PC on bus1
		case (phase)
			PH_FETCH_MAR:
			begin
				ctrl.mar_load = 1'b1; // PC into MAR for the opcode
				ctrl.bus2_sel = BUS2_BUS1;
			end
			PH_FETCH_INC:
			begin
				ctrl.pc_inc = 1'b1;
				ctrl.bus2_sel = BUS2_BUS1;
			end
			PH_FETCH_IR:
			begin
				ctrl.ir_load = 1'b1;
				ctrl.bus2_sel = BUS2_MEM;
			end
			PH_DECODE: ctrl.bus2_sel = BUS2_BUS1;
			PH_OPR_MAR:
			begin
				ctrl.mar_load = 1'b1;
				ctrl.bus2_sel = BUS2_BUS1;
			end
			PH_OPR_INC:
			begin
				ctrl.pc_inc = 1'b1;
				ctrl.bus2_sel = BUS2_MEM;
			end
			PH_ADDR_MAR:
			begin
				ctrl.mar_load = 1'b1; // Operand byte is the data address
				ctrl.bus2_sel = BUS2_MEM;
			end
			PH_MEM_WAIT: ctrl.bus2_sel = BUS2_MEM;
			PH_REG_LOAD:
			begin
				ctrl.a_load = (dec.reg_sel == REG_A);
				ctrl.b_load = (dec.reg_sel == REG_B);
				ctrl.bus2_sel = BUS2_MEM;
			end
			PH_STORE:
			begin
				ctrl.write = 1'b1;
				ctrl.bus1_sel = (dec.reg_sel == REG_B) ? BUS1_B : BUS1_A;
				ctrl.bus2_sel = BUS2_ALU;
			end
			PH_ALU_EXEC:
			begin
				ctrl.a_load = 1'b1;
				ctrl.ccr_load = 1'b1; // Flags follow the ALU result
				ctrl.alu_sel = dec.alu_op;
				ctrl.bus1_sel = BUS1_A;
				ctrl.bus2_sel = BUS2_ALU;
			end
			PH_PC_LOAD:
			begin
				ctrl.pc_load = 1'b1; // Branch target from memory
				ctrl.bus2_sel = BUS2_MEM;
			end
			PH_SKIP_INC:
			begin
				ctrl.pc_inc = 1'b1;
				ctrl.bus2_sel = BUS2_MEM;
			end
			default: ctrl.bus2_sel = BUS2_ALU;
		endcase
	end

endmodule

`default_nettype wire

/* hw/control_unit.sv */
`default_nettype none

`include "cu_params.svh"

module control_unit
(
	input  logic                 Clk,
	input  logic                 Reset,
	input  logic [`CU_DATA_W-1:0] ir,
	input  logic [`CU_CCR_W-1:0]  ccr,
	output cu_pkg::ctrl_word_t   ctrl
);

	import cu_pkg::*;

	decoded_instr_t dec;
	phase_e         phase;

	opcode_decoder u_decoder (
		.ir  (ir),
		.dec (dec)
	);

	phase_sequencer u_sequencer (
		.Clk   (Clk),
		.Reset (Reset),
		.dec   (dec),
		.ccr   (ccr),
		.phase (phase)
	);

	control_word_gen u_word_gen (
		.phase (phase),
		.dec   (dec),
		.ctrl  (ctrl)
	);

endmodule

`default_nettype wire

/* dv/control_unit_assert.sv */
`default_nettype none

module control_unit_assert
(
	input logic               Clk,
	input logic               Reset,
	input cu_pkg::ctrl_word_t ctrl
);

	int unsigned fail_count = 0;

	write_alone: assert property (@(posedge Clk) disable iff (!Reset)
		ctrl.write |-> !(ctrl.a_load || ctrl.b_load || ctrl.mar_load))
	else
	begin
		$error("write asserted together with a register or MAR load");
		fail_count++;
	end

	pc_one_source: assert property (@(posedge Clk) disable iff (!Reset)
		!(ctrl.pc_load && ctrl.pc_inc))
	else
	begin
		$error("pc_load and pc_inc asserted in the same cycle");
		fail_count++;
	end

	one_reg_load: assert property (@(posedge Clk) disable iff (!Reset)
		!(ctrl.a_load && ctrl.b_load))
	else
	begin
		$error("a_load and b_load asserted in the same cycle");
		fail_count++;
	end

	// Opcode fetch follows the PC increment of the fetch sequence
	ir_after_inc: assert property (@(posedge Clk) disable iff (!Reset)
		ctrl.ir_load |-> $past(ctrl.pc_inc))
	else
	begin
		$error("ir_load without pc_inc in the previous cycle");
		fail_count++;
	end

endmodule

bind control_unit control_unit_assert u_assert
(
	.Clk   (Clk),
	.Reset (Reset),
	.ctrl  (ctrl)
);

`default_nettype wire

/* dv/control_unit_tb.sv */
`default_nettype none

`include "cu_params.svh"

module control_unit_tb;

	import cu_pkg::*;

	localparam int WORD_W = $bits(ctrl_word_t);

	logic                  Clk = 1'b0;
	logic                  Reset;
	logic [`CU_DATA_W-1:0] ir;
	logic [`CU_CCR_W-1:0]  ccr;
	ctrl_word_t            ctrl;

	string                 row_name [64]; // Stimulus and expected results, one row per test
	logic [`CU_DATA_W-1:0] row_ir [64];
	logic [`CU_CCR_W-1:0]  row_ccr [64];
	int                    row_len [64];
	ctrl_word_t            row_word [64];
	int                    n_rows = 0;
	int                    pass_cnt = 0;
	int                    fail_cnt = 0;
	int                    seed = 32'h6e99246b;

	control_unit UUT (.Clk(Clk), .Reset(Reset), .ir(ir), .ccr(ccr), .ctrl(ctrl));

	always #20 Clk = ~Clk;

	// Words of fetch address, fetch increment, fetch IR and decode
	function automatic ctrl_word_t fetch_word(input int k);
		ctrl_word_t w;
		w = '0;
		w.mar_load = (k == 0);
		w.pc_inc = (k == 1);
		w.ir_load = (k == 2);
		w.bus2_sel = (k == 2) ? BUS2_MEM : BUS2_BUS1;
		return w;
	endfunction

	function automatic int flag_of(input logic [7:0] op);
		case (op)
			8'h21, 8'h22: return `CU_FLAG_N;
			8'h23, 8'h24: return `CU_FLAG_Z;
			8'h25, 8'h26: return `CU_FLAG_V;
			default: return `CU_FLAG_C;
		endcase
	endfunction

	// Expected cycle count and last word of one instruction
	function automatic void model_row(input logic [7:0] op, input logic [3:0] flags,
		output int len, output ctrl_word_t w);
		logic taken;
		taken = (op == 8'h20) || (flags[flag_of(op)] == op[0]); // Odd opcodes need the flag set
		w = '0;
		case (op)
			8'h86, 8'h87, 8'h88, 8'h89:
			begin
				len = op[0] ? 9 : 7; // Direct mode adds address and wait
				w.a_load = !op[3];
				w.b_load = op[3];
				w.bus2_sel = BUS2_MEM;
			end
			8'h96, 8'h97:
			begin
				len = 8;
				w.write = 1'b1;
				w.bus1_sel = op[0] ? BUS1_B : BUS1_A;
				w.bus2_sel = BUS2_ALU;
			end
			8'h42, 8'h43, 8'h44, 8'h45, 8'h46, 8'h48, 8'h4a, 8'h4b:
			begin
				len = 5;
				w.a_load = 1'b1;
				w.ccr_load = 1'b1;
				w.bus1_sel = BUS1_A;
				w.bus2_sel = BUS2_ALU;
				case (op)
					8'h43: w.alu_sel = ALU_SUB;
					8'h44: w.alu_sel = ALU_AND;
					8'h45: w.alu_sel = ALU_OR;
					8'h46: w.alu_sel = ALU_INC;
					8'h48: w.alu_sel = ALU_DEC;
					8'h4a: w.alu_sel = ALU_XOR;
					8'h4b: w.alu_sel = ALU_NOT;
					default: w.alu_sel = ALU_ADD;
				endcase
			end
			8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h27, 8'h28:
			begin
				len = taken ? 7 : 5;
				w.pc_load = taken;
				w.pc_inc = !taken; // Skip the target byte
				w.bus2_sel = BUS2_MEM;
			end
			default:
			begin
				len = 4; // Undefined opcode ends on the decode word
				w = fetch_word(3);
			end
		endcase
	endfunction

	task automatic add_row(input string name, input logic [7:0] op, input logic [3:0] flags);
		row_name[n_rows] = name;
		row_ir[n_rows] = op;
		row_ccr[n_rows] = flags;
		model_row(op, flags, row_len[n_rows], row_word[n_rows]);
		n_rows++;
	endtask

	task automatic build_table;
		logic [7:0] fixed_ops [19];
		logic [7:0] op;
		logic [3:0] flags;
		int         i;
		fixed_ops = '{8'h86, 8'h87, 8'h88, 8'h89, 8'h96, 8'h97, 8'h42, 8'h43, 8'h44, 8'h45,
			8'h46, 8'h48, 8'h4a, 8'h4b, 8'h20, 8'h00, 8'h47, 8'h49, 8'h4c};
		for (i = 0; i < 19; i++)
			add_row($sformatf("op_%h", fixed_ops[i]), fixed_ops[i], 4'h0);
		// Each conditional branch with its flag set, then with only that flag clear
		for (i = 1; i <= 8; i++)
		begin
			op = 8'h20 + i[7:0];
			flags = 4'h1 << flag_of(op);
			add_row($sformatf("op_%h_flag_set", op), op, flags);
			add_row($sformatf("op_%h_flag_clr", op), op, ~flags);
		end
		for (i = 0; i < 6; i++)
		begin
			op = 8'h20 + 8'($unsigned($random(seed)) % 9);
			flags = 4'($random(seed));
			add_row($sformatf("op_%h_ccr_%h", op, flags), op, flags);
		end
	endtask

	// Starts on the fetch increment word and stops on the next one
	task automatic run_row(input int r);
		ctrl_word_t cur;
		ctrl_word_t h1;
		ctrl_word_t h2;
		int         cnt;
		logic       ok;
		cur = fetch_word(1);
		h1 = '0;
		h2 = '0;
		cnt = 2;
		do
		begin
			@(posedge Clk);
			#2;
			if (cnt == 3)
			begin
				ir = row_ir[r]; // Valid from decode on, like the IR
				ccr = row_ccr[r];
			end
			@(negedge Clk);
			h2 = h1;
			h1 = cur;
			cur = ctrl;
			cnt++;
		end while (cur != fetch_word(1) && cnt < 16);
		ok = (cur == fetch_word(1)) && (h1 == fetch_word(0));
		assert (ok)
		else
		begin
			$display("%s: no new instruction fetch within %0d cycles", row_name[r], cnt);
			fail_cnt++;
		end
		if (ok)
		begin
			ok = (cnt - 2 == row_len[r]) && (h2 == row_word[r]);
			assert (ok)
			else
			begin
				$display("[ERROR] %s: expected %0d cycles ending %h, actual %0d cycles ending %h",
					row_name[r], row_len[r], row_word[r], cnt - 2, h2);
				fail_cnt++;
			end
		end
		if (ok)
		begin
			pass_cnt++;
			$display("[OK] %s: %0d cycles ending %h", row_name[r], cnt - 2, h2);
		end
	endtask

	initial
	begin
		logic [4*WORD_W-1:0] exp_seq;
		logic [4*WORD_W-1:0] got_seq;
		int                  k;
		Reset = 1'b0;
		ir = '0;
		ccr = '0;
		build_table();
		repeat (2) @(posedge Clk);
		#2;
		Reset = 1'b1;
		for (k = 0; k < 4; k++)
		begin
			@(negedge Clk);
			got_seq[k*WORD_W +: WORD_W] = ctrl;
			exp_seq[k*WORD_W +: WORD_W] = fetch_word(k);
		end
		assert (got_seq == exp_seq)
		else
		begin
			$display("[ERROR] reset_fetch: expected %h, actual %h", exp_seq, got_seq);
			fail_cnt++;
		end
		if (got_seq == exp_seq)
		begin
			pass_cnt++;
			$display("[OK] reset_fetch: %h", got_seq);
		end
		k = 0;
		do
		begin
			@(negedge Clk); // IR is 00h, so a 4-cycle no-op runs first
			k++;
		end while (ctrl != fetch_word(1) && k < 16);
		for (k = 0; k < n_rows; k++)
			run_row(k);
		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			pass_cnt, fail_cnt, UUT.u_assert.fail_count);
		if (fail_cnt == 0 && UUT.u_assert.fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// At most 9 cycles per row, 20 more for reset and the first no-op
	initial
	begin
		#1;
		#(n_rows * 9 * 40 + 20 * 40);
		$display("Timeout: the control unit did not finish the %0d table rows", n_rows);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* ctrl_unit.f */
+incdir+hw
hw/cu_pkg.sv
hw/opcode_decoder.sv
hw/phase_sequencer.sv
hw/control_word_gen.sv
hw/control_unit.sv
dv/control_unit_assert.sv
dv/control_unit_tb.sv

/* Bender.yml */
package:
  name: ctrl_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/cu_pkg.sv
      - hw/opcode_decoder.sv
      - hw/phase_sequencer.sv
      - hw/control_word_gen.sv
      - hw/control_unit.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/control_unit_assert.sv
      - dv/control_unit_tb.sv
